//--- build.f
logic/exec_pkg.sv
logic/operand_forward.sv
logic/int_alu.sv
logic/mult_unit.sv
logic/count_unit.sv
logic/mem_access_gen.sv
logic/exec_control.sv
logic/exec_stage.sv
verification/exec_clock_gen.sv
verification/exec_assertions.sv
verification/exec_stage_tb.sv

//--- logic/count_unit.sv
`timescale 1ns/100ps

module count_unit (
    input  logic        Clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        start,
    input  logic        count_ones,
    input  logic [31:0] operand,
    output logic        done,
    output logic [5:0]  count
);
    import exec_pkg::*;

    logic [31:0] work;
    logic        found;
    logic [2:0]  steps_left;
    logic [3:0]  byte_zeros;

    function automatic logic [3:0] leading_zeros8(input logic [7:0] value);
        logic [3:0] n;
        n = 4'd8;
        for (int i = 0; i < 8; i++) begin
            if (value[i]) begin
                n = 4'(7 - i);
            end
        end
        return n;
    endfunction

    assign byte_zeros = leading_zeros8(work[31:24]);

    always_ff @(posedge Clk) begin
        if (reset || flush) begin
            steps_left <= 3'd0;
            done       <= 1'b0;
        end else if (start) begin
            steps_left <= 3'(COUNT_CYCLES);
            done       <= 1'b0;
        end else if (steps_left != 3'd0) begin
            steps_left <= steps_left - 3'd1;
            done       <= (steps_left == 3'd1);
        end
    end

    // CLO inverts the operand so both ops count leading zeros.
    always_ff @(posedge Clk) begin
        if (start) begin
            work  <= count_ones ? ~operand : operand;
            count <= 6'd0;
            found <= 1'b0;
        end else if (steps_left != 3'd0) begin
            work <= work << 8;
            if (!found) begin
                count <= count + {2'b0, byte_zeros};
                found <= (byte_zeros != 4'd8); // A set bit ends the run.
            end
        end
    end

endmodule

//--- logic/exec_control.sv
`timescale 1ns/100ps

module exec_control (
    input  logic                   Clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   mem_stall,
    input  exec_pkg::dec_bundle_t  bundle,
    input  logic [31:0]            alu_value,
    input  logic                   alu_overflow,
    input  logic [3:0]             byte_en,
    input  logic                   mem_read,
    input  logic                   unaligned,
    input  logic [31:0]            rt_value,
    input  logic                   mul_done,
    input  logic [31:0]            product,
    input  logic                   count_done,
    input  logic [5:0]             count,
    output logic                   mul_start,
    output logic                   count_start,
    output logic                   link_bit,
    output logic                   busy,
    output exec_pkg::exec_result_t result
);
    import exec_pkg::*;

    ctrl_state_e  state;
    exec_result_t formed;
    exec_result_t parked;
    logic         accept;
    logic         is_mul;
    logic         is_count;

    assign accept      = (state == ST_RUN) && bundle.valid && !flush && !mem_stall;
    assign is_mul      = (bundle.op == OP_MUL);
    assign is_count    = (bundle.op == OP_CLO) || (bundle.op == OP_CLZ);
    assign mul_start   = accept && is_mul;
    assign count_start = accept && is_count;
    assign busy        = (state != ST_RUN);

    always_comb begin
        formed            = '0;
        formed.valid      = 1'b1;
        formed.op         = bundle.op;
        formed.pc         = bundle.pc;
        formed.dest       = bundle.dest;
        formed.write_en   = bundle.write_en;
        formed.data       = (bundle.op == OP_SC) ? {31'b0, link_bit} : alu_value;
        formed.store_data = rt_value;
        formed.byte_en    = byte_en;
        formed.mem_read   = mem_read;
        formed.overflow   = alu_overflow;
        formed.unaligned  = unaligned;
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state    <= ST_RUN;
            result   <= '0;
            link_bit <= 1'b0;
        end else if (flush) begin
            state  <= ST_RUN; // The parked op is dropped.
            result <= '0;
        end else if (!mem_stall) begin
            case (state)
                ST_RUN: begin
                    if (accept && (is_mul || is_count)) begin
                        state  <= is_mul ? ST_MUL_WAIT : ST_COUNT_WAIT;
                        result <= '0;
                    end else if (accept) begin
                        result <= formed;
                    end else begin
                        result <= '0;
                    end
                    if (accept && bundle.op == OP_LL) begin
                        link_bit <= 1'b1;
                    end else if (accept && bundle.op == OP_SC) begin
                        link_bit <= 1'b0;
                    end
                end
                ST_MUL_WAIT: begin
                    if (mul_done) begin
                        state       <= ST_RUN;
                        result      <= parked;
                        result.data <= product;
                    end
                end
                ST_COUNT_WAIT: begin
                    if (count_done) begin
                        state       <= ST_RUN;
                        result      <= parked;
                        result.data <= {26'b0, count};
                    end
                end
                default: state <= ST_RUN;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            parked <= formed;
        end
    end

endmodule

//--- logic/exec_pkg.sv
package exec_pkg;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_MUL,
        OP_CLO,
        OP_CLZ,
        OP_LW,
        OP_LH,
        OP_LHU,
        OP_LB,
        OP_LBU,
        OP_SW,
        OP_SH,
        OP_SB,
        OP_LL,
        OP_SC
    } exec_op_e;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_MUL_WAIT,
        ST_COUNT_WAIT
    } ctrl_state_e;

    // Register data may be stale and is corrected by forwarding.
    typedef struct packed {
        logic        valid;
        exec_op_e    op;
        logic [31:0] pc;
        logic [4:0]  rs_num;
        logic [4:0]  rt_num;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
        logic [15:0] imm16;
        logic [4:0]  shamt;
        logic [4:0]  dest;
        logic        write_en;
    } dec_bundle_t;

    typedef struct packed {
        logic        write_en;
        logic [4:0]  dest;
        logic [31:0] data;
    } fwd_bundle_t;

    typedef struct packed {
        logic        valid;
        exec_op_e    op;
        logic [31:0] pc;
        logic [4:0]  dest;
        logic        write_en;
        logic [31:0] data;       // Result, address or SC success bit.
        logic [31:0] store_data;
        logic [3:0]  byte_en;
        logic        mem_read;
        logic        overflow;
        logic        unaligned;
    } exec_result_t;

    localparam int MUL_CYCLES   = 4;
    localparam int COUNT_CYCLES = 4;

endpackage

//--- logic/exec_stage.sv
`timescale 1ns/100ps

module exec_stage (
    input  logic                   Clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   mem_stall,
    input  exec_pkg::dec_bundle_t  bundle,
    input  exec_pkg::fwd_bundle_t  fwd,
    output exec_pkg::exec_result_t result,
    output logic                   busy
);
    import exec_pkg::*;

    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [31:0] alu_value;
    logic        alu_overflow;
    logic [3:0]  byte_en;
    logic        mem_read;
    logic        unaligned;
    logic        link_bit;
    logic        mul_start;
    logic        mul_done;
    logic [31:0] product;
    logic        count_start;
    logic        count_done;
    logic [5:0]  count;

    operand_forward u_forward (
        .bundle(bundle), .fwd(fwd), .local_result(result),
        .rs_value(rs_value), .rt_value(rt_value)
    );

    int_alu u_alu (
        .op(bundle.op), .a(rs_value), .b(rt_value), .imm16(bundle.imm16),
        .shamt(bundle.shamt), .value(alu_value), .overflow(alu_overflow)
    );

    mult_unit u_mult (
        .Clk(Clk), .reset(reset), .flush(flush), .start(mul_start),
        .a(rs_value), .b(rt_value), .done(mul_done), .product(product)
    );

    count_unit u_count (
        .Clk(Clk), .reset(reset), .flush(flush), .start(count_start),
        .count_ones(bundle.op == OP_CLO), .operand(rs_value),
        .done(count_done), .count(count)
    );

    mem_access_gen u_mem_access (
        .op(bundle.op), .addr_low(alu_value[1:0]), .link_bit(link_bit),
        .byte_en(byte_en), .mem_read(mem_read), .unaligned(unaligned)
    );

    exec_control u_control (
        .Clk(Clk), .reset(reset), .flush(flush), .mem_stall(mem_stall),
        .bundle(bundle), .alu_value(alu_value), .alu_overflow(alu_overflow),
        .byte_en(byte_en), .mem_read(mem_read), .unaligned(unaligned),
        .rt_value(rt_value), .mul_done(mul_done), .product(product),
        .count_done(count_done), .count(count), .mul_start(mul_start),
        .count_start(count_start), .link_bit(link_bit), .busy(busy), .result(result)
    );

endmodule

//--- logic/int_alu.sv
`timescale 1ns/100ps

module int_alu (
    input  exec_pkg::exec_op_e op,
    input  logic [31:0]        a,
    input  logic [31:0]        b,
    input  logic [15:0]        imm16,
    input  logic [4:0]         shamt,
    output logic [31:0]        value,
    output logic               overflow
);
    import exec_pkg::*;

    logic [31:0] sum;
    logic [31:0] diff;
    logic [31:0] addr;
    logic        add_ovf;
    logic        sub_ovf;

    assign sum  = a + b;
    assign diff = a - b;
    assign addr = a + {{16{imm16[15]}}, imm16}; // Base plus signed offset.

    // Signed overflow shows as a sign flip that the operand signs do not allow.
    assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
    assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb begin
        case (op)
            OP_ADD, OP_ADDU: value = sum;
            OP_SUB:          value = diff;
            OP_AND:          value = a & b;
            OP_OR:           value = a | b;
            OP_XOR:          value = a ^ b;
            OP_SLT:          value = {31'b0, ($signed(a) < $signed(b))};
            OP_SLL:          value = b << shamt;
            OP_SRL:          value = b >> shamt;
            OP_SRA:          value = $signed(b) >>> shamt;
            OP_LUI:          value = {imm16, 16'b0};
            OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU,
            OP_SW, OP_SH, OP_SB, OP_LL, OP_SC: begin
                value = addr;
            end
            default:         value = 32'b0; // MUL and counts come from their units.
        endcase
    end

    // ADDU never traps.
    assign overflow = ((op == OP_ADD) && add_ovf) || ((op == OP_SUB) && sub_ovf);

endmodule

//--- logic/mem_access_gen.sv
`timescale 1ns/100ps

module mem_access_gen (
    input  exec_pkg::exec_op_e op,
    input  logic [1:0]         addr_low,
    input  logic               link_bit,
    output logic [3:0]         byte_en,
    output logic               mem_read,
    output logic               unaligned
);
    import exec_pkg::*;

    logic       is_word;
    logic       is_half;
    logic       is_byte;
    logic       is_store;
    logic [3:0] lanes;

    assign is_word  = op inside {OP_LW, OP_LL, OP_SW, OP_SC};
    assign is_half  = op inside {OP_LH, OP_LHU, OP_SH};
    assign is_byte  = op inside {OP_LB, OP_LBU, OP_SB};
    assign is_store = op inside {OP_SW, OP_SH, OP_SB, OP_SC};
    assign mem_read = op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU, OP_LL};

    assign unaligned = (is_word && addr_low != 2'b00) || (is_half && addr_low[0]);

    always_comb begin
        if (is_word) begin
            lanes = 4'b1111;
        end else if (is_half) begin
            lanes = 4'b0011 << addr_low;
        end else if (is_byte) begin
            lanes = 4'b0001 << addr_low;
        end else begin
            lanes = 4'b0000;
        end
    end

    // A store must not touch memory when misaligned or when SC has lost its link.
    assign byte_en = ((is_store && unaligned) || (op == OP_SC && !link_bit)) ? 4'b0000 : lanes;

endmodule

//--- logic/mult_unit.sv
`timescale 1ns/100ps

module mult_unit (
    input  logic        Clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        start,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        done,
    output logic [31:0] product
);
    import exec_pkg::*;

    logic [31:0] mcand;
    logic [31:0] mplier;
    logic [31:0] partial;
    logic [2:0]  steps_left;

    // Adds the shifted multiplicand for each of the low 8 multiplier bits.
    always_comb begin
        partial = product;
        for (int i = 0; i < 8; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (reset || flush) begin
            steps_left <= 3'd0;
            done       <= 1'b0;
        end else if (start) begin
            steps_left <= 3'(MUL_CYCLES);
            done       <= 1'b0;
        end else if (steps_left != 3'd0) begin
            steps_left <= steps_left - 3'd1;
            done       <= (steps_left == 3'd1); // Stays up until the next start.
        end
    end

    always_ff @(posedge Clk) begin
        if (start) begin
            mcand   <= a;
            mplier  <= b;
            product <= 32'b0;
        end else if (steps_left != 3'd0) begin
            mcand   <= mcand << 8;  // Bits shifted out only affect the high word.
            mplier  <= mplier >> 8;
            product <= partial;
        end
    end

endmodule

//--- logic/operand_forward.sv
`timescale 1ns/100ps

module operand_forward (
    input  exec_pkg::dec_bundle_t  bundle,
    input  exec_pkg::fwd_bundle_t  fwd,
    input  exec_pkg::exec_result_t local_result,
    output logic [31:0]            rs_value,
    output logic [31:0]            rt_value
);
    import exec_pkg::*;

    // The local result wins over the memory stage since it is younger.
    // A load still in execute only holds its address, so mem_read blocks it.
    function automatic logic [31:0] select_operand(
        input logic [4:0]   num,
        input logic [31:0]  stale,
        input exec_result_t local_r,
        input fwd_bundle_t  mem_fwd
    );
        if (local_r.valid && local_r.write_en && !local_r.mem_read &&
            num != 5'd0 && local_r.dest == num) begin
            return local_r.data;
        end else if (mem_fwd.write_en && num != 5'd0 && mem_fwd.dest == num) begin
            return mem_fwd.data;
        end
        return stale;
    endfunction

    assign rs_value = select_operand(bundle.rs_num, bundle.rs_data, local_result, fwd);
    assign rt_value = select_operand(bundle.rt_num, bundle.rt_data, local_result, fwd);

endmodule

//--- run_sim.sh
#!/bin/bash
# Compile with Verilator, run, and decide pass or fail from the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module exec_stage_tb -f build.f \
    -o Vexec_stage_tb \
    && ./obj_dir/Vexec_stage_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- verification/exec_assertions.sv
`timescale 1ns/100ps

module exec_assertions (
    input logic                   Clk,
    input logic                   reset,
    input logic                   flush,
    input logic                   mem_stall,
    input logic                   busy,
    input logic                   mul_start,
    input logic                   count_start,
    input exec_pkg::ctrl_state_e  state,
    input exec_pkg::exec_result_t result
);
    import exec_pkg::*;

    // A parked op keeps busy high until its result is delivered.
    busy_until_result: assert property (@(posedge Clk) disable iff (reset)
        state != ST_RUN && !flush |=> busy || result.valid)
        else $error("busy fell without a result");

    // Flush overrides the stall, so it is excluded here.
    result_held_on_stall: assert property (@(posedge Clk) disable iff (reset)
        mem_stall && !flush |=> $stable(result)) else $error("result moved during stall");

    start_parks_op: assert property (@(posedge Clk) disable iff (reset)
        mul_start || count_start |=> busy && !result.valid)
        else $error("unit started without parking the op");

    flush_clears_valid: assert property (@(posedge Clk) disable iff (reset)
        flush |=> !result.valid) else $error("result valid after flush");

endmodule

//--- verification/exec_clock_gen.sv
`timescale 1ns/100ps

module exec_clock_gen (
    output logic Clk,
    output logic reset
);
    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk; // 8 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge Clk);
        #1 reset = 1'b0;
    end

endmodule

//--- verification/exec_stage_tb.sv
`timescale 1ns/100ps

module exec_stage_tb;
    import exec_pkg::*;

    typedef struct packed {
        exec_op_e    op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        logic [4:0]  sh;
        logic        fwd_en;
        logic [31:0] fwd_data;
        logic        auto;       // Expected values come from the reference functions.
        logic [31:0] exp_data;
        logic [3:0]  exp_be;
        logic        exp_ua;
    } row_t;

    localparam int TIMEOUT = 20;

    logic         Clk;
    logic         reset;
    logic         flush;
    logic         mem_stall;
    dec_bundle_t  bundle;
    fwd_bundle_t  fwd;
    exec_result_t result;
    exec_result_t saved;
    logic         busy;
    logic [31:0]  lfsr;
    row_t         table_rows[$];
    int           errors;
    int           checks;

    exec_clock_gen clock_gen (.Clk(Clk), .reset(reset));

    exec_stage DUT (
        .Clk(Clk), .reset(reset), .flush(flush), .mem_stall(mem_stall),
        .bundle(bundle), .fwd(fwd), .result(result), .busy(busy)
    );

    bind exec_control exec_assertions u_assert (
        .Clk(Clk), .reset(reset), .flush(flush), .mem_stall(mem_stall), .busy(busy),
        .mul_start(mul_start), .count_start(count_start), .state(state), .result(result)
    );

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    function automatic logic [31:0] expect_data(input exec_op_e op, input logic [31:0] a,
                                                input logic [31:0] b, input logic [15:0] imm,
                                                input logic [4:0] sh);
        case (op)
            OP_ADD, OP_ADDU: return a + b;
            OP_SUB:          return a - b;
            OP_AND:          return a & b;
            OP_OR:           return a | b;
            OP_XOR:          return a ^ b;
            OP_SLT:          return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLL:          return b << sh;
            OP_SRL:          return b >> sh;
            OP_SRA:          return 32'($signed(b) >>> sh);
            OP_LUI:          return {imm, 16'h0000};
            OP_MUL:          return a * b;
            OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU, OP_SW, OP_SH, OP_SB: begin
                return a + {{16{imm[15]}}, imm};
            end
            default:         return 32'd0;
        endcase
    endfunction

    function automatic logic expect_ovf(input exec_op_e op, input logic [31:0] a,
                                        input logic [31:0] b);
        logic [32:0] wide;
        wide = '0;
        if (op == OP_ADD) wide = {a[31], a} + {b[31], b};
        if (op == OP_SUB) wide = {a[31], a} - {b[31], b};
        return wide[32] != wide[31]; // Sign bits disagree when the 32-bit result wrapped.
    endfunction

    function automatic logic is_load(input exec_op_e op);
        return op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU, OP_LL};
    endfunction

    // Returns {unaligned, byte_en} for ordinary loads and stores.
    function automatic logic [4:0] expect_mem(input exec_op_e op, input logic [1:0] off);
        logic [3:0] be;
        logic       ua;
        be = 4'b0000;
        ua = 1'b0;
        case (op)
            OP_LW, OP_SW: begin
                be = 4'b1111;
                ua = (off != 2'd0);
            end
            OP_LH, OP_LHU, OP_SH: begin
                be = 4'b0011 << off;
                ua = off[0];
            end
            OP_LB, OP_LBU, OP_SB: be = 4'b0001 << off;
            default: be = 4'b0000;
        endcase
        if (ua && !is_load(op)) be = 4'b0000;
        return {ua, be};
    endfunction

    task automatic add_row(input exec_op_e op, input logic [4:0] rs, input logic [4:0] rt,
                           input logic [4:0] dest, input logic [31:0] a, input logic [31:0] b,
                           input logic [15:0] imm, input logic fwd_en,
                           input logic [31:0] fwd_data, input logic auto,
                           input logic [31:0] exp_data, input logic [3:0] exp_be);
        row_t r;
        r = '{op, rs, rt, dest, a, b, imm, 5'(imm), fwd_en, fwd_data, auto, exp_data,
              exp_be, 1'b0};
        table_rows.push_back(r);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_row(input row_t r);
        int          edges;
        int          latency;
        logic [4:0]  mem_exp;
        logic [31:0] exp_data;
        bundle = '{1'b1, r.op, 32'h400, r.rs, r.rt, r.a, r.b, r.imm, r.sh, r.dest, 1'b1};
        fwd    = '{r.fwd_en, r.rs, r.fwd_data};
        @(posedge Clk);
        #1;
        bundle.valid = 1'b0;
        fwd.write_en = 1'b0;
        latency = (r.op == OP_MUL) ? MUL_CYCLES + 1 :
                  (r.op inside {OP_CLO, OP_CLZ}) ? COUNT_CYCLES + 1 : 0;
        edges = 0;
        while (!result.valid && edges < TIMEOUT) begin
            check_value("busy", busy, 1'b1);
            @(posedge Clk);
            #1;
            edges++;
        end
        if (!result.valid) begin
            $display("Timeout: no valid result for op %s", r.op.name());
            errors++;
        end
        check_value("latency", edges, latency);
        exp_data = r.auto ? expect_data(r.op, r.a, r.b, r.imm, r.sh) : r.exp_data;
        mem_exp  = r.auto ? expect_mem(r.op, exp_data[1:0]) : {r.exp_ua, r.exp_be};
        check_value("result.data", result.data, exp_data);
        check_value("result.byte_en", result.byte_en, mem_exp[3:0]);
        check_value("result.unaligned", result.unaligned, mem_exp[4]);
        check_value("result.mem_read", result.mem_read, is_load(r.op));
        check_value("result.overflow", result.overflow, expect_ovf(r.op, r.a, r.b));
        check_value("result.op", result.op, r.op);
        check_value("result.pc", result.pc, 32'h400);
        check_value("result.dest", result.dest, r.dest);
        check_value("result.write_en", result.write_en, 1'b1);
        // No row forwards rt, so the store data is the decode value.
        check_value("result.store_data", result.store_data, r.b);
    endtask

    initial begin
        exec_op_e arith_ops[$];
        exec_op_e mem_ops[$];
        int       wait_edges;
        flush     = 1'b0;
        mem_stall = 1'b0;
        bundle    = '0;
        fwd       = '0;
        lfsr      = 32;
        errors    = 0;
        checks    = 0;

        arith_ops = '{OP_ADD, OP_ADDU, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL,
                      OP_SRL, OP_SRA, OP_LUI, OP_MUL};
        foreach (arith_ops[i]) begin
            repeat (2) begin
                add_row(arith_ops[i], 0, 0, 0, take_bits(32), take_bits(32),
                        16'(take_bits(16)), 0, 0, 1, 0, 0);
            end
        end
        add_row(OP_ADD, 0, 0, 0, 32'h7fff_ffff, 32'd1, 0, 0, 0, 1, 0, 0);
        add_row(OP_ADDU, 0, 0, 0, 32'h7fff_ffff, 32'd1, 0, 0, 0, 1, 0, 0);
        add_row(OP_SUB, 0, 0, 0, 32'h8000_0000, 32'd1, 0, 0, 0, 1, 0, 0);
        mem_ops = '{OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU, OP_SW, OP_SH, OP_SB};
        foreach (mem_ops[i]) begin
            for (int off = 0; off < 4; off++) begin
                add_row(mem_ops[i], 0, 0, 0, 32'h1000, 32'h55, 16'(off), 0, 0, 1, 0, 0);
            end
        end
        // Forwarding: local result, memory-stage forward, then a load that must not forward.
        add_row(OP_ADDU, 2, 3, 1, 32'd5, 32'd7, 0, 0, 0, 0, 32'd12, 4'b0000);
        add_row(OP_ADDU, 1, 3, 4, 32'd100, 32'd7, 0, 0, 0, 0, 32'd19, 4'b0000);
        add_row(OP_ADDU, 9, 3, 6, 32'd0, 32'd7, 0, 1, 32'd1000, 0, 32'd1007, 4'b0000);
        add_row(OP_LW, 10, 0, 5, 32'h100, 32'd0, 16'd4, 0, 0, 0, 32'h104, 4'b1111);
        add_row(OP_ADDU, 5, 3, 7, 32'd3, 32'd7, 0, 0, 0, 0, 32'd10, 4'b0000);
        add_row(OP_CLZ, 0, 0, 8, 32'h0, 0, 0, 0, 0, 0, 32'd32, 4'b0000);
        add_row(OP_CLZ, 0, 0, 8, 32'h00f0_0000, 0, 0, 0, 0, 0, 32'd8, 4'b0000);
        add_row(OP_CLO, 0, 0, 8, 32'hffff_ffff, 0, 0, 0, 0, 0, 32'd32, 4'b0000);
        add_row(OP_CLO, 0, 0, 8, 32'h0, 0, 0, 0, 0, 0, 32'd0, 4'b0000);
        add_row(OP_CLO, 0, 0, 8, 32'hff80_0000, 0, 0, 0, 0, 0, 32'd9, 4'b0000);
        add_row(OP_LL, 0, 0, 9, 32'h200, 0, 0, 0, 0, 0, 32'h200, 4'b1111);
        add_row(OP_SC, 0, 0, 9, 32'h200, 0, 0, 0, 0, 0, 32'd1, 4'b1111);
        add_row(OP_SC, 0, 0, 9, 32'h200, 0, 0, 0, 0, 0, 32'd0, 4'b0000);

        wait_edges = 0;
        do begin
            @(posedge Clk);
            wait_edges++;
        end while (reset && wait_edges < TIMEOUT);
        if (reset) begin
            $display("Timeout: reset was never released");
            errors++;
        end
        #1;
        foreach (table_rows[i]) apply_row(table_rows[i]);

        // A flush while MUL is parked drops it.
        bundle = '{1'b1, OP_MUL, 32'h500, 5'd0, 5'd0, 32'd3, 32'd5, 16'd0, 5'd0, 5'd2, 1'b1};
        @(posedge Clk);
        #1;
        bundle.valid = 1'b0;
        @(posedge Clk);
        #1;
        flush = 1'b1;
        @(posedge Clk);
        #1;
        flush = 1'b0;
        check_value("busy", busy, 1'b0);
        repeat (8) begin
            check_value("result.valid", result.valid, 1'b0);
            @(posedge Clk);
            #1;
        end
        apply_row('{OP_MUL, 5'd0, 5'd0, 5'd2, 32'd6, 32'd7, 16'd0, 5'd0, 1'b0, 32'd0,
                    1'b1, 32'd0, 4'b0000, 1'b0});

        // Three cycles of back-pressure hold the result.
        apply_row('{OP_ADDU, 5'd0, 5'd0, 5'd2, 32'd20, 32'd22, 16'd0, 5'd0, 1'b0, 32'd0,
                    1'b1, 32'd0, 4'b0000, 1'b0});
        saved     = result;
        mem_stall = 1'b1;
        bundle = '{1'b1, OP_ADDU, 32'h600, 5'd0, 5'd0, 32'd1, 32'd1, 16'd0, 5'd0, 5'd3, 1'b1};
        repeat (3) begin
            @(posedge Clk);
            #1;
            checks++;
            if (result !== saved) begin
                $display("[FAIL] %0d ns result: got %h, expected %h", $time, result, saved);
                errors++;
            end
        end
        mem_stall = 1'b0;
        @(posedge Clk);
        #1;
        bundle.valid = 1'b0;
        check_value("result.data", result.data, 32'd2);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
